// File: rv_cpu.f
+incdir+include
hw/rv_isa_pkg.sv
hw/rv_pipe_pkg.sv
hw/rv_pipe_if.sv
hw/rv_fetch.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_memory.sv
hw/rv_cpu.sv
tb/rv_cpu_assert.sv
tb/rv_cpu_tb.sv

// File: Bender.yml
package:
  name: rv_cpu

sources:
  - include_dirs:
      - include
    files:
      - hw/rv_isa_pkg.sv
      - hw/rv_pipe_pkg.sv
      - hw/rv_pipe_if.sv
      - hw/rv_fetch.sv
      - hw/rv_decode.sv
      - hw/rv_execute.sv
      - hw/rv_memory.sv
      - hw/rv_cpu.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/rv_cpu_assert.sv
      - tb/rv_cpu_tb.sv

// File: tb/rv_cpu_tb.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_cpu_tb;

  localparam int n_progs      = 6;
  localparam int prog_words   = 16;
  localparam int max_checks   = 10;
  localparam int halt_timeout = 500;
  localparam logic [31:0] nop    = 32'h0000_0013;  // addi x0, x0, 0
  localparam logic [31:0] ecall  = 32'h0000_0073;
  localparam logic [11:0] marker = 12'h666;        // wrong-path value

  logic                clk;
  logic                reset;
  logic                imem_we;
  logic [`RV_XLEN-1:0] imem_addr;
  logic [31:0]         imem_data;
  logic [4:0]          dbg_reg_addr;
  logic [`RV_XLEN-1:0] dbg_reg_data;
  logic                is_halted;

  // program table and expected register values
  logic [31:0] prog_mem [n_progs][prog_words];
  logic [4:0]  chk_reg  [n_progs][max_checks];
  logic [31:0] chk_val  [n_progs][max_checks];
  int          n_words  [n_progs];
  int          n_chks   [n_progs];

  rv_cpu dut0 (
    .clk          (clk),
    .reset        (reset),
    .imem_we      (imem_we),
    .imem_addr    (imem_addr),
    .imem_data    (imem_data),
    .dbg_reg_addr (dbg_reg_addr),
    .dbg_reg_data (dbg_reg_data),
    .is_halted    (is_halted)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // instruction encoders
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1);
    return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};  // sw only
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  function automatic logic [31:0] addi(input logic [4:0] rd, input logic [4:0] rs1,
                                       input logic [11:0] imm);
    return enc_i(imm, rs1, 3'b000, rd, 7'b0010011);
  endfunction

  task automatic emit(input int p, input logic [31:0] w);
    prog_mem[p][n_words[p]] = w;
    n_words[p]++;
  endtask

  task automatic expect_reg(input int p, input logic [4:0] r, input logic [31:0] v);
    chk_reg[p][n_chks[p]] = r;
    chk_val[p][n_chks[p]] = v;
    n_chks[p]++;
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    if (got !== exp) begin
      abort_run($sformatf("ERR %0t: %s is %h, expected %h", $time, what, got, exp));
    end
  endtask

  task automatic build_table();
    for (int p = 0; p < n_progs; p++) begin
      n_words[p] = 0;
      n_chks[p]  = 0;
      for (int i = 0; i < prog_words; i++) begin
        prog_mem[p][i] = nop;
      end
    end
    // program 0 has back-to-back dependent ALU ops
    emit(0, addi(1, 0, 12'd5));
    emit(0, addi(2, 1, 12'd7));
    emit(0, enc_r(7'h00, 2, 1, 3'b000, 3));             // add x3, x1, x2
    emit(0, enc_r(7'h20, 1, 3, 3'b000, 4));             // sub x4, x3, x1
    emit(0, enc_i(12'd2, 4, 3'b001, 5, 7'b0010011));    // slli
    emit(0, enc_i(12'hfff, 5, 3'b100, 6, 7'b0010011));  // xori -1
    emit(0, enc_i(12'h404, 6, 3'b101, 7, 7'b0010011));  // srai 4
    emit(0, enc_r(7'h00, 1, 7, 3'b010, 8));             // slt x8, x7, x1
    emit(0, addi(0, 1, 12'd9));                         // x0 stays zero
    emit(0, enc_r(7'h00, 1, 0, 3'b000, 9));             // add x9, x0, x1
    emit(0, addi(17, 0, 12'd10));
    emit(0, ecall);
    expect_reg(0, 1, 32'd5);
    expect_reg(0, 2, 32'd12);
    expect_reg(0, 3, 32'd17);
    expect_reg(0, 4, 32'd12);
    expect_reg(0, 5, 32'd48);
    expect_reg(0, 6, 32'hffff_ffcf);
    expect_reg(0, 7, 32'hffff_fffc);
    expect_reg(0, 8, 32'd1);
    expect_reg(0, 9, 32'd5);
    expect_reg(0, 0, 32'd0);
    // program 1 stores, loads and adds the loaded word
    emit(1, addi(1, 0, 12'd100));
    emit(1, addi(2, 0, 12'h123));
    emit(1, enc_s(12'd8, 2, 1));
    emit(1, enc_i(12'd8, 1, 3'b010, 3, 7'b0000011));    // lw x3, 8(x1)
    emit(1, enc_r(7'h00, 1, 3, 3'b000, 4));             // load-use
    emit(1, enc_s(12'd12, 4, 1));
    emit(1, enc_i(12'd12, 1, 3'b010, 5, 7'b0000011));
    emit(1, addi(6, 5, 12'd9));
    emit(1, addi(17, 0, 12'd10));
    emit(1, ecall);
    expect_reg(1, 3, 32'h123);
    expect_reg(1, 4, 32'h123 + 32'd100);
    expect_reg(1, 5, 32'h123 + 32'd100);
    expect_reg(1, 6, 32'h123 + 32'd109);
    // program 2 mixes taken and not-taken branches
    emit(2, addi(1, 0, 12'd3));
    emit(2, addi(2, 0, 12'd3));
    emit(2, addi(10, 0, 12'd1));
    emit(2, addi(12, 0, 12'd2));
    emit(2, addi(13, 0, 12'd3));
    emit(2, enc_b(13'd8, 2, 1, 3'b000));                // beq taken
    emit(2, addi(10, 0, marker));
    emit(2, enc_b(13'd8, 2, 1, 3'b001));                // bne not taken
    emit(2, addi(11, 0, 12'h055));
    emit(2, enc_b(13'd12, 1, 0, 3'b100));               // blt x0, x1 is taken
    emit(2, addi(12, 0, marker));
    emit(2, addi(13, 0, marker));
    emit(2, addi(17, 0, 12'd10));
    emit(2, ecall);
    expect_reg(2, 10, 32'd1);
    expect_reg(2, 11, 32'h55);
    expect_reg(2, 12, 32'd2);
    expect_reg(2, 13, 32'd3);
    // program 3 jumps with jal and jalr
    emit(3, addi(10, 0, 12'd1));
    emit(3, addi(11, 0, 12'd2));
    emit(3, enc_j(21'd12, 1));                          // pc 8 -> 20
    emit(3, addi(10, 0, marker));
    emit(3, addi(11, 0, marker));
    emit(3, addi(5, 0, 12'd40));
    emit(3, enc_i(12'd4, 5, 3'b000, 6, 7'b1100111));    // jalr pc 24 -> 44
    emit(3, addi(10, 0, marker));
    emit(3, addi(11, 0, marker));
    emit(3, nop);
    emit(3, nop);
    emit(3, enc_r(7'h00, 6, 1, 3'b000, 7));
    emit(3, addi(17, 0, 12'd10));
    emit(3, ecall);
    expect_reg(3, 1, 32'd12);
    expect_reg(3, 6, 32'd28);
    expect_reg(3, 7, 32'd40);
    expect_reg(3, 10, 32'd1);
    expect_reg(3, 11, 32'd2);
    // program 4 has a non-halting ecall before the halting one
    emit(4, addi(20, 0, 12'd7));
    emit(4, addi(21, 0, 12'd8));
    emit(4, addi(22, 0, 12'd9));
    emit(4, addi(17, 0, 12'd5));
    emit(4, ecall);
    emit(4, addi(20, 0, 12'd70));
    emit(4, addi(17, 0, 12'd10));
    emit(4, ecall);
    emit(4, addi(21, 0, marker));
    emit(4, addi(22, 0, marker));
    expect_reg(4, 17, 32'd10);
    expect_reg(4, 20, 32'd70);
    expect_reg(4, 21, 32'd8);
    expect_reg(4, 22, 32'd9);
    // program 5 restarts from 0 and its link value shows the absolute pc
    emit(5, addi(1, 0, 12'h011));
    emit(5, enc_j(21'd4, 2));
    emit(5, addi(3, 2, 12'd1));
    emit(5, addi(17, 0, 12'd10));
    emit(5, ecall);
    expect_reg(5, 1, 32'h11);
    expect_reg(5, 2, 32'd8);
    expect_reg(5, 3, 32'd9);
  endtask

  initial begin
    int cycles;
    reset        = 1'b1;
    imem_we      = 1'b0;
    imem_addr    = '0;
    imem_data    = '0;
    dbg_reg_addr = '0;
    build_table();

    for (int p = 0; p < n_progs; p++) begin
      @(posedge clk);
      #1;
      reset = 1'b1;
      for (int i = 0; i < prog_words; i++) begin  // whole window so stale words get overwritten
        imem_we   = 1'b1;
        imem_addr = 32'(i * 4);
        imem_data = prog_mem[p][i];
        @(posedge clk);
        #1;
      end
      imem_we = 1'b0;
      repeat (3) begin
        @(posedge clk);
      end
      #1;
      reset = 1'b0;
      check_value(32'(is_halted), 32'd0, $sformatf("is_halted after reset, program %0d", p));

      cycles = 0;
      while (!is_halted && cycles < halt_timeout) begin
        @(posedge clk);
        #1;
        cycles++;
      end
      if (!is_halted) begin
        abort_run($sformatf("program %0d never halted within %0d cycles", p, halt_timeout));
      end
      $display("program %0d halted after %0d cycles", p, cycles);

      for (int k = 0; k < n_chks[p]; k++) begin
        dbg_reg_addr = chk_reg[p][k];  // read port settles within the cycle
        @(posedge clk);
        #1;
        check_value(dbg_reg_data, chk_val[p][k],
                    $sformatf("program %0d x%0d", p, chk_reg[p][k]));
      end
      dbg_reg_addr = '0;
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// File: tb/rv_cpu_assert.sv
`timescale 1ns/10ps

module rv_cpu_assert (
  input logic        clk,
  input logic        reset,
  input logic        is_halted,
  input logic [4:0]  dbg_reg_addr,
  input logic [31:0] dbg_reg_data
);

  // halt flag cleared by reset
  halt_low_after_reset: assert property (@(posedge clk) reset |=> !is_halted)
    else $error("is_halted high in the cycle after reset");

  // sticky until the next reset
  halt_sticky: assert property (@(posedge clk) (is_halted && !reset) |=> is_halted)
    else $error("is_halted dropped without reset");

  x0_reads_zero: assert property (@(posedge clk) (dbg_reg_addr == 5'd0) |-> (dbg_reg_data == '0))
    else $error("debug read of x0 is not zero");

endmodule

bind rv_cpu rv_cpu_assert u_assert (
  .clk          (clk),
  .reset        (reset),
  .is_halted    (is_halted),
  .dbg_reg_addr (dbg_reg_addr),
  .dbg_reg_data (dbg_reg_data)
);

// File: hw/rv_cpu.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_cpu (
  input  logic                clk,
  input  logic                reset,
  input  logic                imem_we,
  input  logic [`RV_XLEN-1:0] imem_addr,
  input  logic [31:0]         imem_data,
  input  logic [4:0]          dbg_reg_addr,
  output logic [`RV_XLEN-1:0] dbg_reg_data,
  output logic                is_halted
);

  // IF/ID
  logic                if_valid;
  logic [`RV_XLEN-1:0] if_pc;
  logic [31:0]         if_instr;

  // flow control
  logic                stall, halt_fetch, redirect;
  logic [`RV_XLEN-1:0] redirect_pc;

  // ID/EX
  logic                ex_valid;
  logic [`RV_XLEN-1:0] ex_pc, ex_rs1_data, ex_rs2_data, ex_imm;
  logic [4:0]          ex_rs1, ex_rs2, ex_rd;
  logic [31:0]         ex_instr;
  logic                ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg;
  logic                ex_branch, ex_jal, ex_jalr, ex_halt;

  // EX/MEM
  logic                mem_valid;
  logic [`RV_XLEN-1:0] mem_alu_out, mem_store_data;
  logic [4:0]          mem_rd;
  logic                mem_read, mem_write, mem_reg_write, mem_mem_to_reg;
  logic                mem_link, mem_halt;

  // MEM/WB
  logic                wb_we;
  logic [4:0]          wb_rd;
  logic [`RV_XLEN-1:0] wb_data;

  fwd_if fwd ();

  rv_fetch u_fetch (.*);

  rv_decode u_decode (
    .flush (redirect),  // taken branch or jump kills decode
    .fwd   (fwd),
    .*
  );

  rv_execute u_execute (
    .fwd (fwd),
    .*
  );

  rv_memory u_memory (
    .fwd (fwd),
    .*
  );

endmodule

// File: hw/rv_memory.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_memory import rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      mem_valid,
  input  word_t     mem_alu_out,
  input  word_t     mem_store_data,
  input  reg_addr_t mem_rd,
  input  logic      mem_read,
  input  logic      mem_write,
  input  logic      mem_reg_write,
  input  logic      mem_mem_to_reg,
  input  logic      mem_link,
  input  logic      mem_halt,
  fwd_if.source     fwd,
  output logic      wb_we,
  output reg_addr_t wb_rd,
  output word_t     wb_data,
  output logic      is_halted
);

  localparam int dmem_aw = $clog2(`RV_DMEM_WORDS);

  word_t              dmem [`RV_DMEM_WORDS];
  logic [dmem_aw-1:0] dmem_idx;
  word_t              load_data;
  word_t              mem_result;

  assign dmem_idx = mem_alu_out[dmem_aw+1:2];  // word index

  always_ff @(posedge clk) begin
    if (mem_valid && mem_write) begin
      dmem[dmem_idx] <= mem_store_data;
    end
  end

  assign load_data = mem_read ? dmem[dmem_idx] : '0;

  // link results already carry pc + 4
  assign mem_result = (mem_mem_to_reg && !mem_link) ? load_data : mem_alu_out;

  assign fwd.mem_we   = mem_valid && mem_reg_write;
  assign fwd.mem_rd   = mem_rd;
  assign fwd.mem_data = mem_result;  // load data usable as well
  assign fwd.wb_we    = wb_we;
  assign fwd.wb_rd    = wb_rd;
  assign fwd.wb_data  = wb_data;

  always_ff @(posedge clk) begin
    if (reset) begin
      wb_we     <= 1'b0;
      is_halted <= 1'b0;
    end else begin
      wb_we <= mem_valid && mem_reg_write;
      if (mem_valid && mem_halt) begin
        is_halted <= 1'b1;  // ecall enters writeback, sticky
      end
    end
  end

  // MEM/WB payload
  always_ff @(posedge clk) begin
    wb_rd   <= mem_rd;
    wb_data <= mem_result;
  end

endmodule

// File: hw/rv_execute.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_execute import rv_isa_pkg::*, rv_pipe_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      ex_valid,
  input  word_t     ex_pc,
  input  reg_addr_t ex_rs1,
  input  reg_addr_t ex_rs2,
  input  reg_addr_t ex_rd,
  input  word_t     ex_rs1_data,
  input  word_t     ex_rs2_data,
  input  word_t     ex_imm,
  input  instr_t    ex_instr,
  input  logic      ex_alu_src,
  input  logic      ex_mem_read,
  input  logic      ex_mem_write,
  input  logic      ex_reg_write,
  input  logic      ex_mem_to_reg,
  input  logic      ex_branch,
  input  logic      ex_jal,
  input  logic      ex_jalr,
  input  logic      ex_halt,
  fwd_if.sink       fwd,
  output logic      redirect,
  output word_t     redirect_pc,
  output logic      mem_valid,
  output word_t     mem_alu_out,
  output word_t     mem_store_data,
  output reg_addr_t mem_rd,
  output logic      mem_read,
  output logic      mem_write,
  output logic      mem_reg_write,
  output logic      mem_mem_to_reg,
  output logic      mem_link,
  output logic      mem_halt
);

  opcode_e    opcode;
  logic [2:0] funct3;
  alu_op_e    alu_op;
  fwd_sel_e   sel_a, sel_b;
  word_t      op_a, op_b, rs2_fwd, alu_out;
  word_t      branch_pc, link_pc;
  logic [$clog2(`RV_XLEN)-1:0] shamt;
  logic       taken;

  // memory stage is newer than writeback
  function automatic fwd_sel_e fwd_pick(reg_addr_t rs);
    if (fwd.mem_we && fwd.mem_rd != '0 && fwd.mem_rd == rs) begin
      return fwd_mem;
    end
    if (fwd.wb_we && fwd.wb_rd != '0 && fwd.wb_rd == rs) begin
      return fwd_wb;
    end
    return fwd_reg;
  endfunction

  assign opcode = opcode_e'(ex_instr[6:0]);
  assign funct3 = ex_instr[14:12];

  always_comb begin
    alu_op = alu_add;  // address add for load, store, jalr
    case (opcode)
      opc_op, opc_op_imm: begin
        case (funct3)
          3'b000:  alu_op = (opcode == opc_op && ex_instr[30]) ? alu_sub : alu_add;
          3'b001:  alu_op = alu_sll;
          3'b010:  alu_op = alu_slt;
          3'b011:  alu_op = alu_sltu;
          3'b100:  alu_op = alu_xor;
          3'b101:  alu_op = ex_instr[30] ? alu_sra : alu_srl;
          3'b110:  alu_op = alu_or;
          default: alu_op = alu_and;
        endcase
      end
      opc_branch: begin
        case (funct3)
          3'b000:  alu_op = alu_eq;
          3'b001:  alu_op = alu_ne;
          3'b100:  alu_op = alu_lt;
          3'b101:  alu_op = alu_ge;
          3'b110:  alu_op = alu_ltu;
          default: alu_op = alu_geu;
        endcase
      end
      default: alu_op = alu_add;
    endcase
  end

  // operand forwarding
  always_comb begin
    sel_a = fwd_pick(ex_rs1);
    sel_b = fwd_pick(ex_rs2);
    case (sel_a)
      fwd_mem: op_a = fwd.mem_data;
      fwd_wb:  op_a = fwd.wb_data;
      default: op_a = ex_rs1_data;
    endcase
    case (sel_b)
      fwd_mem: rs2_fwd = fwd.mem_data;
      fwd_wb:  rs2_fwd = fwd.wb_data;
      default: rs2_fwd = ex_rs2_data;
    endcase
  end

  assign op_b  = ex_alu_src ? ex_imm : rs2_fwd;
  assign shamt = op_b[$clog2(`RV_XLEN)-1:0];

  always_comb begin
    case (alu_op)
      alu_add:  alu_out = op_a + op_b;
      alu_sub:  alu_out = op_a - op_b;
      alu_and:  alu_out = op_a & op_b;
      alu_or:   alu_out = op_a | op_b;
      alu_xor:  alu_out = op_a ^ op_b;
      alu_sll:  alu_out = op_a << shamt;
      alu_srl:  alu_out = op_a >> shamt;
      alu_sra:  alu_out = word_t'($signed(op_a) >>> shamt);
      alu_slt:  alu_out = word_t'($signed(op_a) < $signed(op_b));
      alu_sltu: alu_out = word_t'(op_a < op_b);
      alu_eq:   alu_out = word_t'(op_a == op_b);
      alu_ne:   alu_out = word_t'(op_a != op_b);
      alu_lt:   alu_out = word_t'($signed(op_a) < $signed(op_b));
      alu_ge:   alu_out = word_t'($signed(op_a) >= $signed(op_b));
      alu_ltu:  alu_out = word_t'(op_a < op_b);
      default:  alu_out = word_t'(op_a >= op_b);
    endcase
  end

  assign taken     = ex_branch && alu_out[0];
  assign branch_pc = ex_pc + ex_imm;
  assign link_pc   = ex_pc + word_t'(4);

  assign redirect    = ex_valid && (ex_jal || ex_jalr || taken);
  assign redirect_pc = ex_jalr ? {alu_out[`RV_XLEN-1:1], 1'b0} : branch_pc;

  // EX/MEM control
  always_ff @(posedge clk) begin
    if (reset) begin
      mem_valid <= 1'b0;
      {mem_read, mem_write, mem_reg_write, mem_mem_to_reg, mem_link, mem_halt} <= '0;
    end else begin
      mem_valid <= ex_valid;
      {mem_read, mem_write, mem_reg_write, mem_mem_to_reg} <=
        {ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg};
      mem_link <= ex_jal || ex_jalr;
      mem_halt <= ex_halt;
    end
  end

  // EX/MEM payload
  always_ff @(posedge clk) begin
    mem_alu_out    <= (ex_jal || ex_jalr) ? link_pc : alu_out;  // link value pc + 4
    mem_store_data <= rs2_fwd;
    mem_rd         <= ex_rd;
  end

endmodule

// File: hw/rv_decode.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_decode import rv_isa_pkg::*; (
  input  logic      clk,
  input  logic      reset,
  input  logic      if_valid,
  input  word_t     if_pc,
  input  instr_t    if_instr,
  input  logic      flush,
  input  logic      wb_we,
  input  reg_addr_t wb_rd,
  input  word_t     wb_data,
  fwd_if.sink       fwd,
  output logic      stall,
  output logic      halt_fetch,
  input  reg_addr_t dbg_reg_addr,
  output word_t     dbg_reg_data,
  output logic      ex_valid,
  output word_t     ex_pc,
  output reg_addr_t ex_rs1,
  output reg_addr_t ex_rs2,
  output reg_addr_t ex_rd,
  output word_t     ex_rs1_data,
  output word_t     ex_rs2_data,
  output word_t     ex_imm,
  output instr_t    ex_instr,
  output logic      ex_alu_src,
  output logic      ex_mem_read,
  output logic      ex_mem_write,
  output logic      ex_reg_write,
  output logic      ex_mem_to_reg,
  output logic      ex_branch,
  output logic      ex_jal,
  output logic      ex_jalr,
  output logic      ex_halt
);

  localparam reg_addr_t halt_reg = reg_addr_t'(`RV_HALT_REG);

  word_t     regs [`RV_NREGS];
  opcode_e   opcode;
  reg_addr_t rs1, rs2, rd;
  word_t     rs1_data, rs2_data, imm, halt_val;
  logic      is_ecall, uses_rs1, uses_rs2;
  logic      alu_src, mem_read, mem_write, reg_write, mem_to_reg;
  logic      branch, jal, jalr;
  logic      load_use, ecall_wait, halt_det, halt_seen, bubble;

  // write-through from writeback and x0 reads zero
  function automatic word_t rf_read(reg_addr_t a);
    if (a == '0) begin
      return '0;
    end
    if (wb_we && wb_rd == a) begin
      return wb_data;
    end
    return regs[a];
  endfunction

  always_ff @(posedge clk) begin
    if (wb_we && wb_rd != '0) begin
      regs[wb_rd] <= wb_data;
    end
  end

  assign opcode   = opcode_e'(if_instr[6:0]);
  assign is_ecall = (if_instr == 32'h0000_0073);
  assign rs1      = is_ecall ? halt_reg : if_instr[19:15];  // ecall reads x17
  assign rs2      = if_instr[24:20];
  assign rd       = if_instr[11:7];

  always_comb begin
    rs1_data     = rf_read(rs1);
    rs2_data     = rf_read(rs2);
    dbg_reg_data = rf_read(dbg_reg_addr);
  end

  // control and immediates
  always_comb begin
    {alu_src, mem_read, mem_write, reg_write, mem_to_reg} = '0;
    {branch, jal, jalr, uses_rs1, uses_rs2} = '0;
    imm = '0;
    case (opcode)
      opc_op: begin
        {reg_write, uses_rs1, uses_rs2} = 3'b111;
      end
      opc_op_imm: begin
        {alu_src, reg_write, uses_rs1} = 3'b111;
        imm = word_t'(signed'(if_instr[31:20]));
      end
      opc_load: begin
        {alu_src, mem_read, mem_to_reg, reg_write, uses_rs1} = 5'b11111;
        imm = word_t'(signed'(if_instr[31:20]));
      end
      opc_store: begin
        {alu_src, mem_write, uses_rs1, uses_rs2} = 4'b1111;
        imm = word_t'(signed'({if_instr[31:25], if_instr[11:7]}));
      end
      opc_branch: begin
        {branch, uses_rs1, uses_rs2} = 3'b111;
        imm = word_t'(signed'({if_instr[31], if_instr[7], if_instr[30:25],
                               if_instr[11:8], 1'b0}));
      end
      opc_jal: begin
        {jal, reg_write} = 2'b11;
        imm = word_t'(signed'({if_instr[31], if_instr[19:12], if_instr[20],
                               if_instr[30:21], 1'b0}));
      end
      opc_jalr: begin
        {jalr, alu_src, reg_write, uses_rs1} = 4'b1111;
        imm = word_t'(signed'(if_instr[31:20]));
      end
      default: ;  // system and unknown act as nop
    endcase
  end

  assign load_use = if_valid && ex_valid && ex_mem_read && ex_rd != '0 &&
                    ((uses_rs1 && ex_rd == rs1) || (uses_rs2 && ex_rd == rs2));

  // x17 still in execute cannot be forwarded here
  assign ecall_wait = if_valid && is_ecall && ex_valid && ex_reg_write && ex_rd == halt_reg;
  assign stall      = load_use || ecall_wait;

  // newest value of x17, writeback already comes through rf_read
  always_comb begin
    if (fwd.mem_we && fwd.mem_rd == halt_reg) begin
      halt_val = fwd.mem_data;
    end else begin
      halt_val = rs1_data;
    end
  end

  assign halt_det   = if_valid && is_ecall && !flush && !ecall_wait &&
                      halt_val == word_t'(`RV_HALT_CODE);
  assign halt_fetch = halt_det || halt_seen;
  assign bubble     = flush || stall || !if_valid;

  // ID/EX control
  always_ff @(posedge clk) begin
    if (reset) begin
      ex_valid  <= 1'b0;
      halt_seen <= 1'b0;
      {ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg} <= '0;
      {ex_branch, ex_jal, ex_jalr, ex_halt} <= '0;
    end else begin
      if (halt_det) begin
        halt_seen <= 1'b1;
      end
      if (bubble) begin
        ex_valid <= 1'b0;
        {ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg} <= '0;
        {ex_branch, ex_jal, ex_jalr, ex_halt} <= '0;
      end else begin
        ex_valid <= 1'b1;
        {ex_alu_src, ex_mem_read, ex_mem_write, ex_reg_write, ex_mem_to_reg} <=
          {alu_src, mem_read, mem_write, reg_write, mem_to_reg};
        {ex_branch, ex_jal, ex_jalr, ex_halt} <= {branch, jal, jalr, halt_det};
      end
    end
  end

  // ID/EX payload
  always_ff @(posedge clk) begin
    ex_pc       <= if_pc;
    ex_rs1      <= rs1;
    ex_rs2      <= rs2;
    ex_rd       <= rd;
    ex_rs1_data <= rs1_data;
    ex_rs2_data <= rs2_data;
    ex_imm      <= imm;
    ex_instr    <= if_instr;
  end

endmodule

// File: hw/rv_fetch.sv
`timescale 1ns/10ps
`include "rv_consts.svh"

module rv_fetch import rv_isa_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   stall,
  input  logic   halt_fetch,
  input  logic   redirect,
  input  word_t  redirect_pc,
  input  logic   imem_we,
  input  word_t  imem_addr,
  input  instr_t imem_data,
  output logic   if_valid,
  output word_t  if_pc,
  output instr_t if_instr
);

  localparam int imem_aw = $clog2(`RV_IMEM_WORDS);

  instr_t imem [`RV_IMEM_WORDS];
  word_t  pc;
  instr_t fetch_instr;

  // program load port
  always_ff @(posedge clk) begin
    if (imem_we) begin
      imem[imem_addr[imem_aw+1:2]] <= imem_data;
    end
  end

  assign fetch_instr = imem[pc[imem_aw+1:2]];  // async read

  always_ff @(posedge clk) begin
    if (reset) begin
      pc       <= '0;
      if_valid <= 1'b0;
    end else if (redirect) begin
      pc       <= redirect_pc;
      if_valid <= 1'b0;  // drop wrong-path fetch
    end else if (halt_fetch) begin
      if_valid <= 1'b0;  // pc frozen, bubbles only
    end else if (!stall) begin
      pc       <= pc + word_t'(4);
      if_valid <= 1'b1;
    end
  end

  // IF/ID payload held during a stall
  always_ff @(posedge clk) begin
    if (!stall) begin
      if_pc    <= pc;
      if_instr <= fetch_instr;
    end
  end

endmodule

// File: hw/rv_pipe_if.sv
`timescale 1ns/10ps

// results that are not yet in the register file
interface fwd_if import rv_isa_pkg::*; ();

  logic      mem_we;    // memory stage
  reg_addr_t mem_rd;
  word_t     mem_data;
  logic      wb_we;     // writeback stage
  reg_addr_t wb_rd;
  word_t     wb_data;

  modport source (
    output mem_we,
    output mem_rd,
    output mem_data,
    output wb_we,
    output wb_rd,
    output wb_data
  );

  modport sink (
    input mem_we,
    input mem_rd,
    input mem_data,
    input wb_we,
    input wb_rd,
    input wb_data
  );

endinterface

// File: hw/rv_pipe_pkg.sv
package rv_pipe_pkg;

  // last six entries are branch compares with a 1-bit result
  typedef enum logic [3:0] {
    alu_add  = 4'd0,
    alu_sub  = 4'd1,
    alu_and  = 4'd2,
    alu_or   = 4'd3,
    alu_xor  = 4'd4,
    alu_sll  = 4'd5,
    alu_srl  = 4'd6,
    alu_sra  = 4'd7,
    alu_slt  = 4'd8,
    alu_sltu = 4'd9,
    alu_eq   = 4'd10,
    alu_ne   = 4'd11,
    alu_lt   = 4'd12,
    alu_ge   = 4'd13,
    alu_ltu  = 4'd14,
    alu_geu  = 4'd15
  } alu_op_e;

  // operand source in execute
  typedef enum logic [1:0] {
    fwd_reg = 2'd0,
    fwd_mem = 2'd1,
    fwd_wb  = 2'd2
  } fwd_sel_e;

endpackage

// File: hw/rv_isa_pkg.sv
`include "rv_consts.svh"

package rv_isa_pkg;

  typedef logic [`RV_XLEN-1:0] word_t;             // data or byte address
  typedef logic [31:0] instr_t;
  typedef logic [$clog2(`RV_NREGS)-1:0] reg_addr_t;

  // base opcodes in instr[6:0]
  typedef enum logic [6:0] {
    opc_load   = 7'b0000011,
    opc_op_imm = 7'b0010011,
    opc_store  = 7'b0100011,
    opc_op     = 7'b0110011,
    opc_branch = 7'b1100011,
    opc_jalr   = 7'b1100111,
    opc_jal    = 7'b1101111,
    opc_system = 7'b1110011
  } opcode_e;

endpackage

// File: include/rv_consts.svh
`ifndef RV_CONSTS_SVH
`define RV_CONSTS_SVH

// datapath width and register count
`define RV_XLEN 32
`define RV_NREGS 32

// memory depths in 32-bit words
`define RV_IMEM_WORDS 256
`define RV_DMEM_WORDS 256

// an ecall halts when this register holds the halt code
`define RV_HALT_REG 17
`define RV_HALT_CODE 10

`endif
